// ==== hdl/procPkg.sv ====
`default_nettype none

package procPkg;

	// Machine sizes
	localparam int wordWidth     = 16;
	localparam int numRegs       = 8;
	localparam int dmemDepth     = 256;
	localparam int regIdxWidth   = $clog2(numRegs);
	localparam int dmemAddrWidth = $clog2(dmemDepth);

	typedef logic [wordWidth-1:0]     word_t;
	typedef logic [regIdxWidth-1:0]   regIdx_t;
	typedef logic [dmemAddrWidth-1:0] dmemAddr_t;

	// Opcode in bits 15:12, codes 11 to 14 are illegal
	typedef enum logic [3:0] {
		opNop  = 4'd0,
		opAdd  = 4'd1,
		opSub  = 4'd2,
		opAnd  = 4'd3,
		opXor  = 4'd4,
		opAddi = 4'd5,
		opLbi  = 4'd6,
		opLd   = 4'd7,
		opSt   = 4'd8,
		opBeqz = 4'd9,
		opJ    = 4'd10,
		opHalt = 4'd15
	} opcode_t;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluXor,
		aluPassB
	} aluOp_t;

	// Instruction field positions
	localparam int opHi = 15;
	localparam int opLo = 12;
	localparam int rdHi = 11;
	localparam int rdLo = 9;
	localparam int rsHi = 8;
	localparam int rsLo = 6;
	localparam int rtHi = 5;
	localparam int rtLo = 3;

	// Immediate widths for I-type, LBI/BEQZ and J
	localparam int immIWidth = 6;
	localparam int immLWidth = 9;
	localparam int immJWidth = 12;

	localparam word_t nopInstr = '0;

endpackage

`default_nettype wire

// ==== hdl/fetchStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetchStage (
	input  logic           clk,
	input  logic           rstN,
	input  logic           stall,
	input  logic           branchTaken,
	input  procPkg::word_t branchTarget,
	input  logic           haltSeen,
	input  procPkg::word_t imemData,
	output procPkg::word_t imemAddr,
	output procPkg::word_t instr,
	output procPkg::word_t pcInc
);

	import procPkg::*;

	word_t pc;
	word_t pcNext;
	logic  stopped;

	assign pcNext   = pc + word_t'(1);
	assign imemAddr = pc;

	// Latches once HALT has been decoded, fetch never resumes
	always_ff @(posedge clk) begin
		if (!rstN) begin
			stopped <= 1'b0;
		end else if (haltSeen && !stall) begin
			stopped <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else if (!stall) begin
			if (branchTaken) begin
				pc <= branchTarget;
			end else if (!haltSeen && !stopped) begin
				pc <= pcNext;
			end
		end
	end

	// Fetch-to-decode register; wrong-path words become NOP
	always_ff @(posedge clk) begin
		if (!rstN) begin
			instr <= nopInstr;
		end else if (!stall) begin
			instr <= (branchTaken || haltSeen || stopped) ? nopInstr : imemData;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			pcInc <= pcNext;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/decodeStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
	input  logic             clk,
	input  logic             rstN,
	input  procPkg::word_t   instr,
	input  procPkg::word_t   pcInc,
	input  logic             stall,
	input  logic             commitValid,
	input  procPkg::regIdx_t commitReg,
	input  procPkg::word_t   commitData,
	output procPkg::regIdx_t srcA,
	output procPkg::regIdx_t srcB,
	output logic             useA,
	output logic             useB,
	output logic             branchTaken,
	output procPkg::word_t   branchTarget,
	output logic             haltSeen,
	output procPkg::word_t   exOpA,
	output procPkg::word_t   exOpB,
	output procPkg::word_t   exStoreData,
	output procPkg::aluOp_t  exAluOp,
	output logic             exUseImm,
	output procPkg::word_t   exImm,
	output logic             exMemRead,
	output logic             exMemWrite,
	output logic             exRegWrite,
	output procPkg::regIdx_t exDest,
	output logic             exHalt,
	output logic             err
);

	import procPkg::*;

	word_t   regFile [numRegs];
	opcode_t opcode;
	word_t   immI;
	word_t   immL;
	word_t   offJ;
	word_t   readA;
	word_t   readB;
	word_t   imm;
	aluOp_t  aluOp;
	logic    useImm;
	logic    memRead;
	logic    memWrite;
	logic    regWrite;
	logic    isBeqz;
	logic    isJump;
	logic    illegal;

	assign opcode = opcode_t'(instr[opHi:opLo]);
	assign immI   = {{(wordWidth-immIWidth){instr[immIWidth-1]}}, instr[immIWidth-1:0]};
	assign immL   = {{(wordWidth-immLWidth){instr[immLWidth-1]}}, instr[immLWidth-1:0]};
	assign offJ   = {{(wordWidth-immJWidth){instr[immJWidth-1]}}, instr[immJWidth-1:0]};

	// BEQZ tests the rd field, ST stores the rd field
	assign srcA = (opcode == opBeqz) ? instr[rdHi:rdLo] : instr[rsHi:rsLo];
	assign srcB = (opcode == opSt) ? instr[rdHi:rdLo] : instr[rtHi:rtLo];

	// Commit bypass gives write-before-read
	assign readA = (commitValid && commitReg == srcA) ? commitData : regFile[srcA];
	assign readB = (commitValid && commitReg == srcB) ? commitData : regFile[srcB];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regFile[i] <= '0;
			end
		end else if (commitValid) begin
			regFile[commitReg] <= commitData;
		end
	end

	always_comb begin
		useA     = 1'b0;
		useB     = 1'b0;
		aluOp    = aluAdd;
		useImm   = 1'b0;
		imm      = immI;
		memRead  = 1'b0;
		memWrite = 1'b0;
		regWrite = 1'b0;
		isBeqz   = 1'b0;
		isJump   = 1'b0;
		haltSeen = 1'b0;
		illegal  = 1'b0;
		case (opcode)
			opNop: ;
			opAdd, opSub, opAnd, opXor: begin
				useA     = 1'b1;
				useB     = 1'b1;
				regWrite = 1'b1;
				aluOp    = (opcode == opSub) ? aluSub :
				           (opcode == opAnd) ? aluAnd :
				           (opcode == opXor) ? aluXor : aluAdd;
			end
			opAddi: begin
				useA     = 1'b1;
				useImm   = 1'b1;
				regWrite = 1'b1;
			end
			opLbi: begin
				aluOp    = aluPassB;
				useImm   = 1'b1;
				imm      = immL;
				regWrite = 1'b1;
			end
			opLd: begin
				useA     = 1'b1;
				useImm   = 1'b1;
				memRead  = 1'b1;
				regWrite = 1'b1;
			end
			opSt: begin
				useA     = 1'b1;
				useB     = 1'b1;
				useImm   = 1'b1;
				memWrite = 1'b1;
			end
			opBeqz: begin
				useA   = 1'b1;
				isBeqz = 1'b1;
			end
			opJ:     isJump = 1'b1;
			opHalt:  haltSeen = 1'b1;
			default: illegal = 1'b1;
		endcase
	end

	// Resolved here, so a taken branch costs one bubble
	assign branchTaken  = !stall && (isJump || (isBeqz && readA == '0));
	assign branchTarget = pcInc + (isJump ? offJ : immL);

	// Control into execute, bubble while stalled
	always_ff @(posedge clk) begin
		if (!rstN || stall) begin
			exMemRead  <= 1'b0;
			exMemWrite <= 1'b0;
			exRegWrite <= 1'b0;
			exHalt     <= 1'b0;
		end else begin
			exMemRead  <= memRead;
			exMemWrite <= memWrite;
			exRegWrite <= regWrite;
			exHalt     <= haltSeen;
		end
	end

	always_ff @(posedge clk) begin
		exOpA       <= readA;
		exOpB       <= readB;
		exStoreData <= readB;
		exAluOp     <= aluOp;
		exUseImm    <= useImm;
		exImm       <= imm;
		exDest      <= instr[rdHi:rdLo];
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			err <= 1'b0;
		end else if (illegal) begin
			err <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/hazardUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
	input  procPkg::regIdx_t srcA,
	input  procPkg::regIdx_t srcB,
	input  logic             useA,
	input  logic             useB,
	input  logic             exRegWrite,
	input  procPkg::regIdx_t exDest,
	input  logic             memRegWrite,
	input  procPkg::regIdx_t memDest,
	output logic             stall
);

	logic exHitA;
	logic exHitB;
	logic memHitA;
	logic memHitB;

	// Producers still in execute
	assign exHitA = exRegWrite && exDest == srcA;
	assign exHitB = exRegWrite && exDest == srcB;

	// Producers in the memory stage
	assign memHitA = memRegWrite && memDest == srcA;
	assign memHitB = memRegWrite && memDest == srcB;

	// Commit is covered by the register file bypass
	assign stall = (useA && (exHitA || memHitA)) || (useB && (exHitB || memHitB));

endmodule

`default_nettype wire

// ==== hdl/executeStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module executeStage (
	input  logic               clk,
	input  logic               rstN,
	input  procPkg::word_t     opA,
	input  procPkg::word_t     opB,
	input  procPkg::word_t     storeData,
	input  procPkg::aluOp_t    aluOp,
	input  logic               useImm,
	input  procPkg::word_t     imm,
	input  logic               memRead,
	input  logic               memWrite,
	input  logic               regWrite,
	input  procPkg::regIdx_t   dest,
	input  logic               halt,
	output procPkg::dmemAddr_t memAddr,
	output procPkg::word_t     memStoreData,
	output procPkg::word_t     memResult,
	output logic               memLoad,
	output logic               memStore,
	output logic               memRegWrite,
	output procPkg::regIdx_t   memDest,
	output logic               memHalt
);

	import procPkg::*;

	word_t aluB;
	word_t aluOut;

	assign aluB = useImm ? imm : opB;

	always_comb begin
		case (aluOp)
			aluAdd:  aluOut = opA + aluB;
			aluSub:  aluOut = opA - aluB;
			aluAnd:  aluOut = opA & aluB;
			aluXor:  aluOut = opA ^ aluB;
			default: aluOut = aluB;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			memLoad     <= 1'b0;
			memStore    <= 1'b0;
			memRegWrite <= 1'b0;
			memHalt     <= 1'b0;
		end else begin
			memLoad     <= memRead;
			memStore    <= memWrite;
			memRegWrite <= regWrite;
			memHalt     <= halt;
		end
	end

	// Address wraps at the data memory size
	always_ff @(posedge clk) begin
		memAddr      <= aluOut[dmemAddrWidth-1:0];
		memResult    <= aluOut;
		memStoreData <= storeData;
		memDest      <= dest;
	end

endmodule

`default_nettype wire

// ==== hdl/memoryStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module memoryStage (
	input  logic               clk,
	input  logic               rstN,
	input  procPkg::dmemAddr_t memAddr,
	input  procPkg::word_t     memStoreData,
	input  procPkg::word_t     memResult,
	input  logic               memLoad,
	input  logic               memStore,
	input  logic               memRegWrite,
	input  procPkg::regIdx_t   memDest,
	input  logic               memHalt,
	output logic               commitValid,
	output procPkg::regIdx_t   commitReg,
	output procPkg::word_t     commitData,
	output logic               halted
);

	import procPkg::*;

	word_t dmem [dmemDepth];
	word_t loadData;

	// Asynchronous read, always answers in the same cycle
	assign loadData = dmem[memAddr];

	always_ff @(posedge clk) begin
		if (memStore) begin
			dmem[memAddr] <= memStoreData;
		end
	end

	// Commit register doubles as the writeback stage
	always_ff @(posedge clk) begin
		if (!rstN) begin
			commitValid <= 1'b0;
		end else begin
			commitValid <= memRegWrite;
		end
	end

	always_ff @(posedge clk) begin
		commitReg  <= memDest;
		commitData <= memLoad ? loadData : memResult;
	end

	// Sticky once HALT retires
	always_ff @(posedge clk) begin
		if (!rstN) begin
			halted <= 1'b0;
		end else if (memHalt) begin
			halted <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/proc.sv ====
`timescale 1ns/100ps
`default_nettype none

module proc (
	input  logic             clk,
	input  logic             rstN,
	input  procPkg::word_t   imemData,
	output procPkg::word_t   imemAddr,
	output logic             commitValid,
	output procPkg::regIdx_t commitReg,
	output procPkg::word_t   commitData,
	output logic             halted,
	output logic             err
);

	import procPkg::*;

	// Fetch and decode
	word_t     instr;
	word_t     pcInc;
	logic      branchTaken;
	word_t     branchTarget;
	logic      haltSeen;
	logic      stall;
	regIdx_t   srcA;
	regIdx_t   srcB;
	logic      useA;
	logic      useB;

	// Decode to execute
	word_t     exOpA;
	word_t     exOpB;
	word_t     exStoreData;
	aluOp_t    exAluOp;
	logic      exUseImm;
	word_t     exImm;
	logic      exMemRead;
	logic      exMemWrite;
	logic      exRegWrite;
	regIdx_t   exDest;
	logic      exHalt;

	// Execute to memory
	dmemAddr_t memAddr;
	word_t     memStoreData;
	word_t     memResult;
	logic      memLoad;
	logic      memStore;
	logic      memRegWrite;
	regIdx_t   memDest;
	logic      memHalt;

	// Only decode can detect an illegal opcode here
	logic      decodeErr;

	fetchStage fetch (
		.clk(clk), .rstN(rstN), .stall(stall), .branchTaken(branchTaken),
		.branchTarget(branchTarget), .haltSeen(haltSeen), .imemData(imemData),
		.imemAddr(imemAddr), .instr(instr), .pcInc(pcInc)
	);

	decodeStage decode (
		.clk(clk), .rstN(rstN), .instr(instr), .pcInc(pcInc), .stall(stall),
		.commitValid(commitValid), .commitReg(commitReg), .commitData(commitData),
		.srcA(srcA), .srcB(srcB), .useA(useA), .useB(useB),
		.branchTaken(branchTaken), .branchTarget(branchTarget), .haltSeen(haltSeen),
		.exOpA(exOpA), .exOpB(exOpB), .exStoreData(exStoreData), .exAluOp(exAluOp),
		.exUseImm(exUseImm), .exImm(exImm), .exMemRead(exMemRead),
		.exMemWrite(exMemWrite), .exRegWrite(exRegWrite), .exDest(exDest),
		.exHalt(exHalt), .err(decodeErr)
	);

	hazardUnit hazard (
		.srcA(srcA), .srcB(srcB), .useA(useA), .useB(useB),
		.exRegWrite(exRegWrite), .exDest(exDest),
		.memRegWrite(memRegWrite), .memDest(memDest), .stall(stall)
	);

	executeStage execute (
		.clk(clk), .rstN(rstN), .opA(exOpA), .opB(exOpB), .storeData(exStoreData),
		.aluOp(exAluOp), .useImm(exUseImm), .imm(exImm), .memRead(exMemRead),
		.memWrite(exMemWrite), .regWrite(exRegWrite), .dest(exDest), .halt(exHalt),
		.memAddr(memAddr), .memStoreData(memStoreData), .memResult(memResult),
		.memLoad(memLoad), .memStore(memStore), .memRegWrite(memRegWrite),
		.memDest(memDest), .memHalt(memHalt)
	);

	memoryStage memory (
		.clk(clk), .rstN(rstN), .memAddr(memAddr), .memStoreData(memStoreData),
		.memResult(memResult), .memLoad(memLoad), .memStore(memStore),
		.memRegWrite(memRegWrite), .memDest(memDest), .memHalt(memHalt),
		.commitValid(commitValid), .commitReg(commitReg), .commitData(commitData),
		.halted(halted)
	);

	assign err = decodeErr;

endmodule

`default_nettype wire

// ==== verification/procTb_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module procTb_assert (
	input logic           clk,
	input logic           rstN,
	input procPkg::word_t imemAddr,
	input logic           commitValid,
	input logic           halted,
	input logic           err
);

	int failCount = 0;

	// Reset clears the outputs and points fetch at address 0
	resetState: assert property (@(posedge clk)
		!rstN |=> (!commitValid && !halted && !err && imemAddr == '0))
		else begin
			failCount++;
			$error("Outputs not cleared by reset");
		end

	// Nothing retires behind HALT
	noCommitAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
		halted |-> !commitValid)
		else begin
			failCount++;
			$error("commitValid high while halted");
		end

	haltedSticky: assert property (@(posedge clk) disable iff (!rstN)
		halted |=> halted)
		else begin
			failCount++;
			$error("halted fell without reset");
		end

	errSticky: assert property (@(posedge clk) disable iff (!rstN)
		err |=> err)
		else begin
			failCount++;
			$error("err fell without reset");
		end

endmodule

`default_nettype wire

// ==== verification/procTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module procTb;

	import procPkg::*;

	localparam int progLen = 64;

	logic    clk = 1'b0;
	logic    rstN;
	word_t   imemData;
	word_t   imemAddr;
	logic    commitValid;
	regIdx_t commitReg;
	word_t   commitData;
	logic    halted;
	logic    err;

	logic [31:0] lfsr;
	word_t       imem [progLen];
	word_t       regs [numRegs];
	word_t       dmemModel [dmemDepth];
	bit          written [dmemDepth];
	regIdx_t     expReg [$];
	word_t       expData [$];

	proc dut (
		.clk(clk), .rstN(rstN), .imemData(imemData), .imemAddr(imemAddr),
		.commitValid(commitValid), .commitReg(commitReg), .commitData(commitData),
		.halted(halted), .err(err)
	);

	bind proc procTb_assert checks (
		.clk(clk), .rstN(rstN), .imemAddr(imemAddr),
		.commitValid(commitValid), .halted(halted), .err(err)
	);

	always #50 clk = ~clk;

	// Instruction memory serves NOP outside the program
	always_comb begin
		imemData = nopInstr;
		if (imemAddr < 16'd64) begin
			imemData = imem[imemAddr[5:0]];
		end
	end

	function automatic logic stepLfsr();
		logic outBit;
		outBit = lfsr[0];
		lfsr = lfsr >> 1;
		if (outBit) begin
			lfsr = lfsr ^ 32'h8020_0003;
		end
		return outBit;
	endfunction

	function automatic word_t randBits(input int n);
		word_t value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[14:0], stepLfsr()};
		end
		return value;
	endfunction

	function automatic word_t signExtend6(input logic [5:0] value);
		return {{10{value[5]}}, value};
	endfunction

	function automatic word_t signExtend9(input logic [8:0] value);
		return {{7{value[8]}}, value};
	endfunction

	// Forward only and never past the final HALT
	function automatic word_t forwardOffset(input int pc);
		word_t off;
		word_t room;
		off = randBits(3);
		room = word_t'(progLen - 2 - pc);
		return (off > room) ? room : off;
	endfunction

	task automatic stopOnError();
		$display("FAIL: see errors above");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic writeReg(input regIdx_t rd, input word_t value);
		regs[rd] = value;
		expReg.push_back(rd);
		expData.push_back(value);
	endtask

	// Generates the program and runs the reference model along the taken path
	task automatic buildRandomProgram();
		int         pc;
		int         next;
		word_t      r;
		word_t      a;
		word_t      off;
		word_t      sum;
		regIdx_t    rd;
		regIdx_t    rs;
		regIdx_t    stRs;
		logic [5:0] stImm;
		for (int i = 0; i < numRegs; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < dmemDepth; i++) begin
			written[i] = 1'b0;
		end
		// Slots a branch skips keep this filler
		for (int i = 0; i < progLen - 1; i++) begin
			r = randBits(12);
			imem[i] = {opXor, r[11:0]};
		end
		imem[progLen-1] = {opHalt, 12'h000};
		expReg.delete();
		expData.delete();
		stRs = '0;
		stImm = '0;
		pc = 0;
		while (pc < progLen - 1) begin
			r = randBits(16);
			rd = r[11:9];
			rs = r[8:6];
			a = regs[rs];
			next = pc + 1;
			case (r[15:12])
				4'd0, 4'd1: begin
					imem[pc] = {opAdd, r[11:3], 3'b000};
					writeReg(rd, a + regs[r[5:3]]);
				end
				4'd2: begin
					imem[pc] = {opSub, r[11:3], 3'b000};
					writeReg(rd, a - regs[r[5:3]]);
				end
				4'd3: begin
					imem[pc] = {opAnd, r[11:3], 3'b000};
					writeReg(rd, a & regs[r[5:3]]);
				end
				4'd4: begin
					imem[pc] = {opXor, r[11:3], 3'b000};
					writeReg(rd, a ^ regs[r[5:3]]);
				end
				4'd5, 4'd6: begin
					imem[pc] = {opAddi, r[11:0]};
					writeReg(rd, a + signExtend6(r[5:0]));
				end
				4'd7, 4'd8: begin
					imem[pc] = {opLbi, r[11:0]};
					writeReg(rd, signExtend9(r[8:0]));
				end
				4'd9, 4'd10: begin
					imem[pc] = {opSt, r[11:0]};
					sum = a + signExtend6(r[5:0]);
					dmemModel[sum[7:0]] = regs[rd];
					written[sum[7:0]] = 1'b1;
					stRs = rs;
					stImm = r[5:0];
				end
				4'd11, 4'd12: begin
					// Reuse the last store's address so loads hit written words
					sum = regs[stRs] + signExtend6(stImm);
					if (written[sum[7:0]]) begin
						imem[pc] = {opLd, rd, stRs, stImm};
						writeReg(rd, dmemModel[sum[7:0]]);
					end else begin
						imem[pc] = nopInstr;
					end
				end
				4'd13: begin
					off = forwardOffset(pc);
					imem[pc] = {opBeqz, rd, off[8:0]};
					if (regs[rd] == '0) begin
						next = pc + 1 + int'(off);
					end
				end
				4'd14: begin
					off = forwardOffset(pc);
					imem[pc] = {opJ, off[11:0]};
					next = pc + 1 + int'(off);
				end
				default: imem[pc] = nopInstr;
			endcase
			pc = next;
		end
	endtask

	task automatic buildIllegalProgram();
		for (int i = 0; i < progLen; i++) begin
			imem[i] = nopInstr;
		end
		imem[0] = {opLbi, 3'd1, 9'd5};
		imem[1] = 16'hB000;
		imem[2] = {opAddi, 3'd2, 3'd1, 6'd1};
		imem[3] = {opJ, 12'd1};
		imem[4] = {opLbi, 3'd3, 9'd7};
		imem[5] = {opHalt, 12'h000};
		// A register write behind HALT that must never commit
		imem[6] = {opLbi, 3'd4, 9'd9};
		// Only r1 = 5 and r2 = 6 are written since the J skips the LBI at 4
		expReg.delete();
		expData.delete();
		expReg.push_back(3'd1);
		expData.push_back(16'h0005);
		expReg.push_back(3'd2);
		expData.push_back(16'h0006);
	endtask

	task automatic applyReset();
		@(posedge clk);
		rstN <= 1'b0;
		repeat (5) @(posedge clk);
		rstN <= 1'b1;
	endtask

	task automatic waitForHalt(input int limit);
		int cycles;
		cycles = 0;
		while (halted !== 1'b1 && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		// Run on past HALT so that a late commit or a falling halted shows
		repeat (4) @(posedge clk);
		@(negedge clk);
		if (halted !== 1'b1) begin
			$display("Timed out after %0d cycles waiting for halted", limit);
			stopOnError();
		end else if (expReg.size() != 0) begin
			$display("Halted with %0d expected register writes missing", expReg.size());
			stopOnError();
		end
	endtask

	task automatic waitForErr(input int limit);
		int cycles;
		cycles = 0;
		while (err !== 1'b1 && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (err !== 1'b1) begin
			$display("Timed out after %0d cycles waiting for err", limit);
			stopOnError();
		end
	endtask

	// Commit trace against the model queue
	always @(posedge clk) begin
		if (commitValid === 1'b1) begin
			if (expReg.size() == 0) begin
				$display("Commit to r%0d with no expected register write left", commitReg);
				stopOnError();
			end else if (commitReg !== expReg[0]) begin
				$display("[ERROR] commitReg: got 0x%h, expected 0x%h", commitReg, expReg[0]);
				stopOnError();
			end else if (commitData !== expData[0]) begin
				$display("[ERROR] commitData: got 0x%h, expected 0x%h", commitData, expData[0]);
				stopOnError();
			end else begin
				void'(expReg.pop_front());
				void'(expData.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		if (dut.checks.failCount != 0) begin
			$display("A concurrent assertion on the DUT ports failed");
			stopOnError();
		end
	end

	initial begin
		lfsr = 32'ha1d9_0564;
		rstN = 1'b0;
		buildRandomProgram();
		applyReset();
		waitForHalt(1000);
		if (err !== 1'b0) begin
			$display("[ERROR] err: got 0x%h, expected 0x0", err);
			stopOnError();
		end
		buildIllegalProgram();
		applyReset();
		waitForErr(100);
		waitForHalt(200);
		if (dut.checks.failCount == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			stopOnError();
		end
	end

endmodule

`default_nettype wire

// ==== proc.f ====
hdl/procPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/hazardUnit.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/proc.sv
verification/procTb_assert.sv
verification/procTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= procTb
FILELIST  ?= proc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIMFLAGS  ?= +verilator+error+limit+100
PASS_LINE  = PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIMFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_LINE)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
